// File: design/cpu_defines.svh
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

//////////////////////////////
// datapath widths
//////////////////////////////

`define DATA_WIDTH      32
`define INST_WIDTH      32
`define NUM_REGS_LOG2   5
`define IMM_WIDTH       16

// instruction memory holds 2**IMEM_DEPTH_LOG2 words
`define IMEM_DEPTH_LOG2 6

//////////////////////////////
// instruction fields
//////////////////////////////

`define OPCODE_MSB 31
`define OPCODE_LSB 26
`define RS_MSB     25
`define RS_LSB     21
`define RT_MSB     20
`define RT_LSB     16
`define RD_MSB     15
`define RD_LSB     11
`define IMM_MSB    15
`define IMM_LSB    0

`endif

// File: design/isa_pkg.sv
`include "cpu_defines.svh"

package isa_pkg;

  // opcode field encodings
  // unknown codes are treated as nop by decode
  typedef enum logic [`OPCODE_MSB-`OPCODE_LSB:0] {
    op_nop  = 6'h00,
    op_add  = 6'h01,
    op_sub  = 6'h02,
    op_and  = 6'h03,
    op_or   = 6'h04,
    op_xor  = 6'h05,
    op_slt  = 6'h06,
    op_addi = 6'h08,
    op_ori  = 6'h0d,
    op_halt = 6'h3f
  } opcode_e;

  // register index
  typedef logic [`NUM_REGS_LOG2-1:0] reg_idx_t;

  // raw immediate, zero-extended in execute
  typedef logic [`IMM_WIDTH-1:0] imm_t;

  // full instruction word
  typedef logic [`INST_WIDTH-1:0] instr_t;

endpackage

// File: design/pipe_pkg.sv
`include "cpu_defines.svh"

package pipe_pkg;

  // alu function, picked in decode
  typedef enum logic [2:0] {
    alu_add = 3'd0,
    alu_sub = 3'd1,
    alu_and = 3'd2,
    alu_or  = 3'd3,
    alu_xor = 3'd4,
    // signed compare, result is 1 or 0
    alu_slt = 3'd5
  } alu_op_e;

  // operand source in execute
  typedef enum logic [1:0] {
    fwd_reg = 2'd0,
    fwd_ex  = 2'd1
  } fwd_sel_e;

  // register and alu data word
  typedef logic [`DATA_WIDTH-1:0] data_t;

  // instruction memory word address
  typedef logic [`IMEM_DEPTH_LOG2-1:0] imem_addr_t;

endpackage

// File: design/fetch_unit.sv
`timescale 1ns/1ns

`include "cpu_defines.svh"

module fetch_unit
  import isa_pkg::*;
  import pipe_pkg::*;
#(
  parameter int imem_depth_log2 = `IMEM_DEPTH_LOG2
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       prog_we,
  input  imem_addr_t prog_addr,
  input  instr_t     prog_data,
  input  logic       run,
  output instr_t     instr,
  output logic       instr_valid
);

  typedef enum logic [1:0] {
    fetch_idle,
    fetch_run,
    fetch_done
  } fetch_state_e;

  fetch_state_e               state;
  logic                       run_q;
  logic [imem_depth_log2-1:0] pc;
  instr_t                     imem [2**imem_depth_log2];
  instr_t                     cur_word;
  logic                       last_fetch;

  //////////////////////////////
  // instruction memory
  //////////////////////////////

  // program port, only used while idle
  always_ff @(posedge clk) begin
    if (prog_we) begin
      imem[prog_addr] <= prog_data;
    end
  end

  assign cur_word = imem[pc];

  // halt or the top word ends the run
  assign last_fetch = (opcode_e'(cur_word[`OPCODE_MSB:`OPCODE_LSB]) == op_halt) ||
                      (pc == {imem_depth_log2{1'b1}});

  //////////////////////////////
  // fetch control
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state       <= fetch_idle;
      run_q       <= 1'b0;
      pc          <= '0;
      instr_valid <= 1'b0;
    end else begin
      run_q       <= run;
      instr_valid <= 1'b0;
      case (state)
        fetch_idle: begin
          // start on the rising edge of run
          if (run && !run_q) begin
            state <= fetch_run;
          end
        end
        fetch_run: begin
          instr_valid <= 1'b1;
          pc          <= pc + 1'b1;
          if (last_fetch) begin
            state <= fetch_done;
          end
        end
        default: begin
          // stays here until reset
          state <= fetch_done;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == fetch_run) begin
      instr <= cur_word;
    end
  end

  // loading must not overlap a run
  assert property (@(posedge clk) disable iff (!rst_n) !(prog_we && run));

endmodule

// File: design/decode_stage.sv
`timescale 1ns/1ns

`include "cpu_defines.svh"

module decode_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  instr_t   instr,
  input  logic     instr_valid,
  input  logic     wb_valid,
  input  reg_idx_t wb_reg,
  input  data_t    wb_data,
  output logic     ex_valid,
  output alu_op_e  ex_alu_op,
  output data_t    ex_rs_data,
  output data_t    ex_rt_data,
  output reg_idx_t ex_rs,
  output reg_idx_t ex_rt,
  output imm_t     ex_imm,
  output logic     ex_use_imm,
  output reg_idx_t ex_dst,
  output logic     ex_write,
  output logic     ex_halt
);

  opcode_e  opcode;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t rd;
  imm_t     imm;

  alu_op_e  dec_alu_op;
  logic     dec_use_imm;
  reg_idx_t dec_dst;
  logic     dec_write;
  logic     dec_halt;

  data_t    regs [2**`NUM_REGS_LOG2];
  data_t    rs_data;
  data_t    rt_data;

  assign opcode = opcode_e'(instr[`OPCODE_MSB:`OPCODE_LSB]);
  assign rs     = instr[`RS_MSB:`RS_LSB];
  assign rt     = instr[`RT_MSB:`RT_LSB];
  assign rd     = instr[`RD_MSB:`RD_LSB];
  assign imm    = instr[`IMM_MSB:`IMM_LSB];

  //////////////////////////////
  // control decode
  //////////////////////////////

  always_comb begin
    dec_alu_op  = alu_add;
    dec_use_imm = 1'b0;
    dec_dst     = rd;
    dec_write   = 1'b0;
    dec_halt    = 1'b0;
    case (opcode)
      op_add:  begin dec_alu_op = alu_add; dec_write = 1'b1; end
      op_sub:  begin dec_alu_op = alu_sub; dec_write = 1'b1; end
      op_and:  begin dec_alu_op = alu_and; dec_write = 1'b1; end
      op_or:   begin dec_alu_op = alu_or;  dec_write = 1'b1; end
      op_xor:  begin dec_alu_op = alu_xor; dec_write = 1'b1; end
      op_slt:  begin dec_alu_op = alu_slt; dec_write = 1'b1; end
      op_addi: begin
        dec_alu_op  = alu_add;
        dec_use_imm = 1'b1;
        dec_dst     = rt;
        dec_write   = 1'b1;
      end
      op_ori: begin
        dec_alu_op  = alu_or;
        dec_use_imm = 1'b1;
        dec_dst     = rt;
        dec_write   = 1'b1;
      end
      op_halt: dec_halt = 1'b1;
      default: ;
    endcase
    // writes to r0 are dropped here
    if (dec_dst == '0) begin
      dec_write = 1'b0;
    end
  end

  //////////////////////////////
  // register file
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 2**`NUM_REGS_LOG2; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_valid) begin
      regs[wb_reg] <= wb_data;
    end
  end

  // r0 reads zero, same-cycle write is bypassed
  always_comb begin
    if (rs == '0) begin
      rs_data = '0;
    end else if (wb_valid && (wb_reg == rs)) begin
      rs_data = wb_data;
    end else begin
      rs_data = regs[rs];
    end
    if (rt == '0) begin
      rt_data = '0;
    end else if (wb_valid && (wb_reg == rt)) begin
      rt_data = wb_data;
    end else begin
      rt_data = regs[rt];
    end
  end

  //////////////////////////////
  // decode/execute register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_write <= 1'b0;
      ex_halt  <= 1'b0;
    end else begin
      ex_valid <= instr_valid;
      ex_write <= instr_valid && dec_write;
      ex_halt  <= instr_valid && dec_halt;
    end
  end

  always_ff @(posedge clk) begin
    ex_alu_op  <= dec_alu_op;
    ex_rs_data <= rs_data;
    ex_rt_data <= rt_data;
    ex_rs      <= rs;
    ex_rt      <= rt;
    ex_imm     <= imm;
    ex_use_imm <= dec_use_imm;
    ex_dst     <= dec_dst;
  end

  // execute must never write back to r0
  assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> (wb_reg != '0));

endmodule

// File: design/execute_stage.sv
`timescale 1ns/1ns

`include "cpu_defines.svh"

module execute_stage
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic     clk,
  input  logic     rst_n,
  input  logic     ex_valid,
  input  alu_op_e  ex_alu_op,
  input  data_t    ex_rs_data,
  input  data_t    ex_rt_data,
  input  reg_idx_t ex_rs,
  input  reg_idx_t ex_rt,
  input  imm_t     ex_imm,
  input  logic     ex_use_imm,
  input  reg_idx_t ex_dst,
  input  logic     ex_write,
  input  logic     ex_halt,
  output logic     wb_valid,
  output reg_idx_t wb_reg,
  output data_t    wb_data,
  output logic     halted
);

  fwd_sel_e rs_sel;
  fwd_sel_e rt_sel;
  data_t    rs_val;
  data_t    rt_val;
  data_t    op_a;
  data_t    op_b;
  data_t    imm_ext;
  logic     less;
  data_t    alu_result;

  //////////////////////////////
  // forwarding
  //////////////////////////////

  // previous instruction wrote the register we read
  assign rs_sel = (wb_valid && (wb_reg == ex_rs)) ? fwd_ex : fwd_reg;
  assign rt_sel = (wb_valid && (wb_reg == ex_rt)) ? fwd_ex : fwd_reg;

  always_comb begin
    case (rs_sel)
      fwd_ex:  rs_val = wb_data;
      default: rs_val = ex_rs_data;
    endcase
    case (rt_sel)
      fwd_ex:  rt_val = wb_data;
      default: rt_val = ex_rt_data;
    endcase
  end

  //////////////////////////////
  // alu
  //////////////////////////////

  // i-type immediates are zero-extended
  assign imm_ext = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, ex_imm};

  assign op_a = rs_val;
  assign op_b = ex_use_imm ? imm_ext : rt_val;

  assign less = $signed(op_a) < $signed(op_b);

  always_comb begin
    case (ex_alu_op)
      alu_add: alu_result = op_a + op_b;
      alu_sub: alu_result = op_a - op_b;
      alu_and: alu_result = op_a & op_b;
      alu_or:  alu_result = op_a | op_b;
      alu_xor: alu_result = op_a ^ op_b;
      alu_slt: alu_result = {{(`DATA_WIDTH-1){1'b0}}, less};
      default: alu_result = op_a + op_b;
    endcase
  end

  //////////////////////////////
  // execute/writeback register
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      halted   <= 1'b0;
    end else begin
      wb_valid <= ex_valid && ex_write;
      // sticky until the next reset
      halted   <= halted || (ex_valid && ex_halt);
    end
  end

  always_ff @(posedge clk) begin
    wb_reg  <= ex_dst;
    wb_data <= alu_result;
  end

  // halted holds and nothing is written back after it
  assert property (@(posedge clk) disable iff (!rst_n) halted |=> (halted && !wb_valid));

endmodule

// File: design/cpu_top.sv
`timescale 1ns/1ns

module cpu_top
  import isa_pkg::*;
  import pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       prog_we,
  input  imem_addr_t prog_addr,
  input  instr_t     prog_data,
  input  logic       run,
  output logic       wb_valid,
  output reg_idx_t   wb_reg,
  output data_t      wb_data,
  output logic       halted
);

  // fetch to decode
  instr_t   instr;
  logic     instr_valid;

  // decode to execute
  logic     ex_valid;
  alu_op_e  ex_alu_op;
  data_t    ex_rs_data;
  data_t    ex_rt_data;
  reg_idx_t ex_rs;
  reg_idx_t ex_rt;
  imm_t     ex_imm;
  logic     ex_use_imm;
  reg_idx_t ex_dst;
  logic     ex_write;
  logic     ex_halt;

  fetch_unit u_fetch (
    .clk         (clk),
    .rst_n       (rst_n),
    .prog_we     (prog_we),
    .prog_addr   (prog_addr),
    .prog_data   (prog_data),
    .run         (run),
    .instr       (instr),
    .instr_valid (instr_valid)
  );

  decode_stage u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .instr       (instr),
    .instr_valid (instr_valid),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .ex_valid    (ex_valid),
    .ex_alu_op   (ex_alu_op),
    .ex_rs_data  (ex_rs_data),
    .ex_rt_data  (ex_rt_data),
    .ex_rs       (ex_rs),
    .ex_rt       (ex_rt),
    .ex_imm      (ex_imm),
    .ex_use_imm  (ex_use_imm),
    .ex_dst      (ex_dst),
    .ex_write    (ex_write),
    .ex_halt     (ex_halt)
  );

  execute_stage u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_valid    (ex_valid),
    .ex_alu_op   (ex_alu_op),
    .ex_rs_data  (ex_rs_data),
    .ex_rt_data  (ex_rt_data),
    .ex_rs       (ex_rs),
    .ex_rt       (ex_rt),
    .ex_imm      (ex_imm),
    .ex_use_imm  (ex_use_imm),
    .ex_dst      (ex_dst),
    .ex_write    (ex_write),
    .ex_halt     (ex_halt),
    .wb_valid    (wb_valid),
    .wb_reg      (wb_reg),
    .wb_data     (wb_data),
    .halted      (halted)
  );

endmodule

// File: sim/cpu_model.svh
`ifndef CPU_MODEL_SVH
`define CPU_MODEL_SVH

// one expected register write, {register, data}
typedef logic [`NUM_REGS_LOG2+`DATA_WIDTH-1:0] wr_entry_t;

// runs a program on a software register file, in program order,
// and collects every write that should appear on the writeback port
function automatic void model_run(input instr_t words [2**`IMEM_DEPTH_LOG2],
                                  output wr_entry_t writes [$]);
  data_t    regs [2**`NUM_REGS_LOG2];
  instr_t   w;
  opcode_e  op;
  reg_idx_t rs;
  reg_idx_t rt;
  reg_idx_t dst;
  data_t    a;
  data_t    b;
  data_t    imm_ext;
  data_t    res;
  logic     wr;
  writes = {};
  for (int i = 0; i < 2**`NUM_REGS_LOG2; i++) begin
    regs[i] = '0;
  end
  // the last memory word ends the program like a halt
  for (int pc = 0; pc < 2**`IMEM_DEPTH_LOG2; pc++) begin
    w       = words[pc];
    op      = opcode_e'(w[`OPCODE_MSB:`OPCODE_LSB]);
    if (op == op_halt) begin
      break;
    end
    rs      = w[`RS_MSB:`RS_LSB];
    rt      = w[`RT_MSB:`RT_LSB];
    dst     = w[`RD_MSB:`RD_LSB];
    a       = regs[rs];
    b       = regs[rt];
    imm_ext = {{(`DATA_WIDTH-`IMM_WIDTH){1'b0}}, w[`IMM_WIDTH-1:0]};
    res     = '0;
    wr      = 1'b1;
    case (op)
      op_add:  res = a + b;
      op_sub:  res = a - b;
      op_and:  res = a & b;
      op_or:   res = a | b;
      op_xor:  res = a ^ b;
      op_slt:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      op_addi: begin
        res = a + imm_ext;
        dst = rt;
      end
      op_ori: begin
        res = a | imm_ext;
        dst = rt;
      end
      default: wr = 1'b0;
    endcase
    // r0 stays zero and never shows up on the port
    if (wr && (dst != '0)) begin
      regs[dst] = res;
      writes.push_back({dst, res});
    end
  end
endfunction

`endif

// File: sim/cpu_tb.sv
`timescale 1ns/1ns

`include "cpu_defines.svh"

module cpu_tb
  import isa_pkg::*;
  import pipe_pkg::*;
();

  localparam int imem_words  = 2**`IMEM_DEPTH_LOG2;
  localparam int run_cycles  = 80;
  localparam int watchdog_ns = 6 * (imem_words + run_cycles + 10) * 20 * 2;

  logic       clk;
  logic       rst_n;
  logic       prog_we;
  imem_addr_t prog_addr;
  instr_t     prog_data;
  logic       run;
  logic       wb_valid;
  reg_idx_t   wb_reg;
  data_t      wb_data;
  logic       halted;

  `include "cpu_model.svh"

  instr_t    prog [imem_words];
  int        prog_len;
  wr_entry_t exp_q [$];
  string     cur_test;
  int        errors;
  int        checks;
  int        seed;
  opcode_e   rand_ops [9] = '{op_nop, op_add, op_sub, op_and, op_or,
                              op_xor, op_slt, op_addi, op_ori};

  cpu_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog_we   (prog_we),
    .prog_addr (prog_addr),
    .prog_data (prog_data),
    .run       (run),
    .wb_valid  (wb_valid),
    .wb_reg    (wb_reg),
    .wb_data   (wb_data),
    .halted    (halted)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////
  // program building
  //////////////////////////////

  // rd = rs op rt
  function automatic instr_t enc_r(input opcode_e op, input int rd, input int rs, input int rt);
    return {op, reg_idx_t'(rs), reg_idx_t'(rt), reg_idx_t'(rd), 11'b0};
  endfunction

  // rt = rs op imm
  function automatic instr_t enc_i(input opcode_e op, input int rt, input int rs, input int imm);
    return {op, reg_idx_t'(rs), reg_idx_t'(rt), imm_t'(imm)};
  endfunction

  task automatic clear_program();
    for (int i = 0; i < imem_words; i++) begin
      prog[i] = '0;
    end
    prog_len = 0;
  endtask

  task automatic add_instr(input instr_t w);
    prog[prog_len] = w;
    prog_len++;
  endtask

  //////////////////////////////
  // driving the core
  //////////////////////////////

  task automatic apply_reset();
    @(posedge clk);
    #2;
    rst_n   = 1'b0;
    run     = 1'b0;
    prog_we = 1'b0;
    repeat (10) @(posedge clk);
    #2;
    rst_n = 1'b1;
  endtask

  // whole memory is written so no old program survives
  task automatic load_program();
    for (int i = 0; i < imem_words; i++) begin
      @(posedge clk);
      #2;
      prog_we   = 1'b1;
      prog_addr = imem_addr_t'(i);
      prog_data = prog[i];
    end
    @(posedge clk);
    #2;
    prog_we = 1'b0;
  endtask

  task automatic run_program(input string name, input logic expect_halt);
    int cycles;
    cur_test = name;
    apply_reset();
    load_program();
    model_run(prog, exp_q);
    @(posedge clk);
    #2;
    run    = 1'b1;
    cycles = 0;
    if (expect_halt) begin
      while (!halted && cycles < run_cycles) begin
        @(negedge clk);
        #1;
        cycles++;
      end
      checks++;
      assert (halted) else begin
        errors++;
        $display("%s: halted did not rise within %0d cycles", name, run_cycles);
      end
      if (halted) begin
        checks++;
        assert (exp_q.size() == 0) else begin
          errors++;
          $display("%s: halted rose with %0d writes still missing", name, exp_q.size());
        end
      end
    end else begin
      while (exp_q.size() != 0 && cycles < run_cycles) begin
        @(negedge clk);
        #1;
        cycles++;
      end
      checks++;
      assert (exp_q.size() == 0) else begin
        errors++;
        $display("%s: %0d writes never arrived", name, exp_q.size());
      end
    end
    // any late strobe is caught by the compare process
    repeat (10) @(negedge clk);
    @(posedge clk);
    #2;
    run = 1'b0;
  endtask

  task automatic build_random_program(input int count);
    int k;
    int rd;
    int rs;
    int rt;
    int imm;
    clear_program();
    for (int i = 0; i < count - 1; i++) begin
      k   = $unsigned($random(seed)) % 9;
      rd  = $unsigned($random(seed)) % 8;
      rs  = $unsigned($random(seed)) % 8;
      rt  = $unsigned($random(seed)) % 8;
      imm = $unsigned($random(seed)) % 65536;
      if (rand_ops[k] == op_addi || rand_ops[k] == op_ori) begin
        add_instr(enc_i(rand_ops[k], rd, rs, imm));
      end else begin
        add_instr(enc_r(rand_ops[k], rd, rs, rt));
      end
    end
    add_instr(enc_r(op_halt, 0, 0, 0));
  endtask

  //////////////////////////////
  // writeback compare
  //////////////////////////////

  initial begin
    wr_entry_t exp_w;
    forever begin
      @(negedge clk);
      if (rst_n && wb_valid) begin
        checks++;
        assert (!halted) else begin
          errors++;
          $display("%s: writeback strobe to r%0d after halted", cur_test, wb_reg);
        end
        assert (exp_q.size() != 0) else begin
          errors++;
          $display("%s: writeback strobe to r%0d with no write expected", cur_test, wb_reg);
        end
        if (exp_q.size() != 0) begin
          exp_w = exp_q.pop_front();
          assert (wb_reg == exp_w[`DATA_WIDTH +: `NUM_REGS_LOG2] &&
                  wb_data == exp_w[`DATA_WIDTH-1:0]) else begin
            errors++;
            $display("[FAIL] %s: expected r%0d = 0x%08h, actual r%0d = 0x%08h", cur_test,
                     exp_w[`DATA_WIDTH +: `NUM_REGS_LOG2], exp_w[`DATA_WIDTH-1:0],
                     wb_reg, wb_data);
          end
        end
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns in test %s", watchdog_ns, cur_test);
    $display("Finished with errors");
    $finish;
  end

  //////////////////////////////
  // tests
  //////////////////////////////

  initial begin
    seed      = 24342;
    errors    = 0;
    checks    = 0;
    rst_n     = 1'b0;
    run       = 1'b0;
    prog_we   = 1'b0;
    prog_addr = '0;
    prog_data = '0;
    cur_test  = "idle_after_reset";
    clear_program();

    apply_reset();
    repeat (20) begin
      @(negedge clk);
      checks++;
      assert (!wb_valid && !halted) else begin
        errors++;
        $display("%s: strobe or halted seen while run is low", cur_test);
      end
    end

    // operands spaced out so no forwarding is needed
    clear_program();
    add_instr(enc_i(op_addi, 1, 0, 'h1234));
    add_instr(enc_i(op_ori, 2, 0, 'hfff0));
    add_instr(enc_i(op_addi, 3, 0, 'h8001));
    add_instr(enc_r(op_nop, 0, 0, 0));
    add_instr(enc_r(op_sub, 4, 0, 1));
    add_instr(enc_r(op_nop, 0, 0, 0));
    add_instr(enc_r(op_nop, 0, 0, 0));
    add_instr(enc_r(op_add, 5, 1, 2));
    add_instr(enc_r(op_sub, 6, 1, 2));
    add_instr(enc_r(op_and, 7, 1, 3));
    add_instr(enc_r(op_or, 8, 1, 3));
    add_instr(enc_r(op_xor, 9, 2, 3));
    add_instr(enc_r(op_slt, 10, 4, 1));
    add_instr(enc_r(op_slt, 11, 1, 4));
    add_instr(enc_i(op_addi, 12, 4, 7));
    add_instr(enc_i(op_ori, 13, 4, 'h00ff));
    add_instr(enc_r(op_halt, 0, 0, 0));
    run_program("all_opcodes", 1'b1);

    // distance 1 uses forwarding, distance 2 the register file bypass
    clear_program();
    add_instr(enc_i(op_addi, 1, 0, 3));
    add_instr(enc_r(op_add, 2, 1, 1));
    add_instr(enc_r(op_sub, 3, 2, 1));
    add_instr(enc_r(op_xor, 4, 1, 3));
    add_instr(enc_i(op_ori, 5, 3, 'h10));
    add_instr(enc_r(op_slt, 6, 4, 5));
    add_instr(enc_i(op_addi, 6, 6, 100));
    add_instr(enc_r(op_or, 7, 6, 5));
    add_instr(enc_i(op_addi, 8, 0, 1));
    add_instr(enc_i(op_addi, 8, 8, 1));
    add_instr(enc_i(op_addi, 8, 8, 1));
    add_instr(enc_r(op_add, 9, 8, 8));
    add_instr(enc_r(op_halt, 0, 0, 0));
    run_program("dependent_chains", 1'b1);

    clear_program();
    add_instr(enc_i(op_addi, 1, 0, 7));
    add_instr(enc_i(op_addi, 0, 1, 5));
    add_instr(enc_r(op_add, 0, 1, 1));
    add_instr(enc_r(op_add, 2, 0, 1));
    add_instr(enc_r(op_or, 3, 0, 0));
    add_instr(enc_i(op_ori, 4, 0, 'h55));
    add_instr(enc_r(op_halt, 0, 0, 0));
    run_program("register_zero", 1'b1);

    // every word writes, fetch stops at the top of memory
    clear_program();
    for (int i = 0; i < imem_words; i++) begin
      add_instr(enc_i(op_addi, 1 + i % 4, 1 + (i + 1) % 4, i));
    end
    run_program("end_of_memory", 1'b0);

    build_random_program(50);
    run_program("random_program", 1'b1);

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+design
+incdir+sim
design/isa_pkg.sv
design/pipe_pkg.sv
design/fetch_unit.sv
design/decode_stage.sv
design/execute_stage.sv
design/cpu_top.sv
sim/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module cpu_tb -o cpu_sim \
  > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/cpu_sim > sim.log 2>&1 || { cat sim.log; echo "simulation exited abnormally"; exit 1; }

cat sim.log
grep -q "Finished with errors" sim.log && { echo "FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "no result found in sim.log"; exit 1; }
echo "PASSED"
